//--- source/ooo_pkg.sv
package ooo_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [4:0]  areg_t;
    typedef logic [5:0]  preg_t;
    typedef logic [2:0]  rob_tag_t;
    typedef logic [3:0]  op_t;

    localparam int NUM_AREGS  = 32;
    localparam int NUM_PREGS  = 64;
    localparam int FREE_DEPTH = NUM_PREGS - NUM_AREGS;
    localparam int ROB_DEPTH  = 8;
    localparam int RS_DEPTH   = 4;
    localparam int MUL_CYCLES = 32;  // one multiplier bit per step

    // RV32 major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    localparam op_t OP_ADD  = 4'd0;
    localparam op_t OP_SUB  = 4'd1;
    localparam op_t OP_AND  = 4'd2;
    localparam op_t OP_OR   = 4'd3;
    localparam op_t OP_XOR  = 4'd4;
    localparam op_t OP_SLL  = 4'd5;
    localparam op_t OP_SRL  = 4'd6;
    localparam op_t OP_SRA  = 4'd7;
    localparam op_t OP_SLT  = 4'd8;
    localparam op_t OP_SLTU = 4'd9;
    localparam op_t OP_MUL  = 4'd10;  // only op routed to the multiplier

    typedef enum logic {
        MUL_IDLE,
        MUL_BUSY
    } mul_state_e;

endpackage

//--- source/inst_decoder.sv
`timescale 1ns/100ps
module inst_decoder (
    input  ooo_pkg::xlen_t inst,
    output ooo_pkg::areg_t rs1,
    output ooo_pkg::areg_t rs2,
    output ooo_pkg::areg_t rd,
    output ooo_pkg::op_t   op,
    output logic           use_imm,
    output ooo_pkg::xlen_t imm,
    output logic           rd_we
);
    import ooo_pkg::*;

    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       supported;
    op_t        alu_op;

    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign rd     = inst[11:7];
    assign rd_we  = supported && (rd != '0);

    // bit 30 only matters for the shift-right pair here
    always_comb begin
        case (funct3)
            3'b000:  alu_op = OP_ADD;
            3'b001:  alu_op = OP_SLL;
            3'b010:  alu_op = OP_SLT;
            3'b011:  alu_op = OP_SLTU;
            3'b100:  alu_op = OP_XOR;
            3'b101:  alu_op = inst[30] ? OP_SRA : OP_SRL;
            3'b110:  alu_op = OP_OR;
            default: alu_op = OP_AND;
        endcase
    end

    always_comb begin
        rs1       = inst[19:15];
        rs2       = inst[24:20];
        op        = alu_op;
        use_imm   = 1'b0;
        imm       = {{20{inst[31]}}, inst[31:20]};
        supported = 1'b1;
        case (inst[6:0])
            OPC_OP: begin
                if (funct7 == 7'b0000001) begin
                    op        = OP_MUL;
                    supported = (funct3 == 3'b000);  // MULH* not handled
                end else if (funct3 == 3'b000 && inst[30]) begin
                    op = OP_SUB;
                end
            end
            OPC_OP_IMM: begin
                rs2     = '0;  // x0 is always ready
                use_imm = 1'b1;
            end
            OPC_LUI: begin
                rs1     = '0;
                rs2     = '0;
                op      = OP_ADD;
                use_imm = 1'b1;
                imm     = {inst[31:12], 12'b0};
            end
            default: supported = 1'b0;
        endcase
    end

endmodule

//--- source/rename_table.sv
`timescale 1ns/100ps
module rename_table (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           rename_en,
    input  ooo_pkg::areg_t rs1,
    input  ooo_pkg::areg_t rs2,
    input  ooo_pkg::areg_t rd,
    input  logic           rd_we,
    output ooo_pkg::preg_t src1_preg,
    output ooo_pkg::preg_t src2_preg,
    output ooo_pkg::preg_t dest_preg,
    output ooo_pkg::preg_t old_preg,
    output logic           free_empty,
    input  logic           release_en,
    input  ooo_pkg::preg_t release_preg
);
    import ooo_pkg::*;

    preg_t rat       [NUM_AREGS];
    preg_t free_list [FREE_DEPTH];

    logic [$clog2(FREE_DEPTH)-1:0] fl_head;
    logic [$clog2(FREE_DEPTH)-1:0] fl_tail;
    logic [$clog2(FREE_DEPTH):0]   fl_count;
    logic                          pop;

    assign pop = rename_en && rd_we;

    assign src1_preg  = rat[rs1];
    assign src2_preg  = rat[rs2];
    assign old_preg   = rat[rd];  // handed back to the free list at commit
    assign dest_preg  = rd_we ? free_list[fl_head] : '0;
    assign free_empty = (fl_count == '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_AREGS; i++)
                rat[i] <= preg_t'(i);
            for (int i = 0; i < FREE_DEPTH; i++)
                free_list[i] <= preg_t'(NUM_AREGS + i);
            fl_head  <= '0;
            fl_tail  <= '0;
            fl_count <= FREE_DEPTH[$clog2(FREE_DEPTH):0];
        end else begin
            if (pop) begin
                rat[rd] <= free_list[fl_head];
                fl_head <= fl_head + 1'b1;
            end
            if (release_en) begin
                free_list[fl_tail] <= release_preg;
                fl_tail            <= fl_tail + 1'b1;
            end
            if (release_en && !pop)
                fl_count <= fl_count + 1'b1;
            else if (pop && !release_en)
                fl_count <= fl_count - 1'b1;
        end
    end

endmodule

//--- source/phys_reg_file.sv
`timescale 1ns/100ps
module phys_reg_file (
    input  logic           clk,
    input  logic           arst_n,
    input  ooo_pkg::preg_t rd_addr1,
    input  ooo_pkg::preg_t rd_addr2,
    output ooo_pkg::xlen_t rd_data1,
    output ooo_pkg::xlen_t rd_data2,
    output logic           rd_valid1,
    output logic           rd_valid2,
    input  logic           alloc_en,
    input  ooo_pkg::preg_t alloc_preg,
    input  logic           cdb_valid,
    input  ooo_pkg::preg_t cdb_preg,
    input  ooo_pkg::xlen_t cdb_value
);
    import ooo_pkg::*;

    xlen_t                regs [NUM_PREGS];
    logic [NUM_PREGS-1:0] valid;

    assign rd_data1  = regs[rd_addr1];
    assign rd_data2  = regs[rd_addr2];
    assign rd_valid1 = valid[rd_addr1];
    assign rd_valid2 = valid[rd_addr2];

    // preg 0 stays valid and zero
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid <= '1;
            for (int i = 0; i < NUM_PREGS; i++)
                regs[i] <= '0;
        end else begin
            if (cdb_valid && cdb_preg != '0) begin
                regs[cdb_preg]  <= cdb_value;
                valid[cdb_preg] <= 1'b1;
            end
            if (alloc_en && alloc_preg != '0)
                valid[alloc_preg] <= 1'b0;  // pending until broadcast
        end
    end

endmodule

//--- source/reservation_station.sv
`timescale 1ns/100ps
module reservation_station (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             insert_en,
    input  ooo_pkg::op_t     op,
    input  logic             use_imm,
    input  ooo_pkg::xlen_t   imm,
    input  ooo_pkg::preg_t   src1_preg,
    input  ooo_pkg::preg_t   src2_preg,
    input  logic             src1_ready,
    input  logic             src2_ready,
    input  ooo_pkg::xlen_t   src1_value,
    input  ooo_pkg::xlen_t   src2_value,
    input  ooo_pkg::preg_t   dest_preg,
    input  ooo_pkg::rob_tag_t tag,
    output logic             rs_full,
    input  logic             alu_free,
    input  logic             mul_free,
    input  logic             cdb_valid,
    input  ooo_pkg::preg_t   cdb_preg,
    input  ooo_pkg::xlen_t   cdb_value,
    output logic             issue_valid,
    output ooo_pkg::op_t     issue_op,
    output ooo_pkg::xlen_t   issue_a,
    output ooo_pkg::xlen_t   issue_b,
    output ooo_pkg::preg_t   issue_preg,
    output ooo_pkg::rob_tag_t issue_tag
);
    import ooo_pkg::*;

    logic [RS_DEPTH-1:0] ent_valid, a_rdy, b_rdy, wake_a, wake_b;
    op_t      ent_op   [RS_DEPTH];
    preg_t    a_preg   [RS_DEPTH];
    preg_t    b_preg   [RS_DEPTH];
    xlen_t    a_val    [RS_DEPTH];
    xlen_t    b_val    [RS_DEPTH];
    preg_t    ent_dest [RS_DEPTH];
    rob_tag_t ent_tag  [RS_DEPTH];

    logic [$clog2(RS_DEPTH)-1:0] ins_idx, iss_idx;
    logic                        hit1, hit2;

    // result arriving in the insert cycle
    assign hit1    = cdb_valid && !src1_ready && (cdb_preg == src1_preg);
    assign hit2    = cdb_valid && !src2_ready && !use_imm && (cdb_preg == src2_preg);
    assign rs_full = &ent_valid;

    // downward scan so the lowest index wins
    always_comb begin
        ins_idx     = '0;
        iss_idx     = '0;
        issue_valid = 1'b0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            wake_a[i] = cdb_valid && ent_valid[i] && !a_rdy[i] && (a_preg[i] == cdb_preg);
            wake_b[i] = cdb_valid && ent_valid[i] && !b_rdy[i] && (b_preg[i] == cdb_preg);
            if (!ent_valid[i])
                ins_idx = i[$clog2(RS_DEPTH)-1:0];
            if (ent_valid[i] && a_rdy[i] && b_rdy[i] &&
                ((ent_op[i] == OP_MUL) ? mul_free : alu_free)) begin
                iss_idx     = i[$clog2(RS_DEPTH)-1:0];
                issue_valid = 1'b1;
            end
        end
    end

    assign issue_op   = ent_op[iss_idx];
    assign issue_a    = a_val[iss_idx];
    assign issue_b    = b_val[iss_idx];
    assign issue_preg = ent_dest[iss_idx];
    assign issue_tag  = ent_tag[iss_idx];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ent_valid <= '0;
            a_rdy     <= '0;
            b_rdy     <= '0;
        end else begin
            a_rdy <= a_rdy | wake_a;
            b_rdy <= b_rdy | wake_b;
            if (issue_valid)
                ent_valid[iss_idx] <= 1'b0;
            if (insert_en) begin
                ent_valid[ins_idx] <= 1'b1;
                a_rdy[ins_idx]     <= src1_ready || hit1;
                b_rdy[ins_idx]     <= use_imm || src2_ready || hit2;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (wake_a[i])
                a_val[i] <= cdb_value;
            if (wake_b[i])
                b_val[i] <= cdb_value;
        end
        if (insert_en) begin
            ent_op[ins_idx]   <= op;
            a_preg[ins_idx]   <= src1_preg;
            b_preg[ins_idx]   <= src2_preg;
            a_val[ins_idx]    <= hit1 ? cdb_value : src1_value;
            b_val[ins_idx]    <= use_imm ? imm : (hit2 ? cdb_value : src2_value);
            ent_dest[ins_idx] <= dest_preg;
            ent_tag[ins_idx]  <= tag;
        end
    end

endmodule

//--- source/exec_unit.sv
`timescale 1ns/100ps
module exec_unit (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              issue_valid,
    input  ooo_pkg::op_t      issue_op,
    input  ooo_pkg::xlen_t    issue_a,
    input  ooo_pkg::xlen_t    issue_b,
    input  ooo_pkg::preg_t    issue_preg,
    input  ooo_pkg::rob_tag_t issue_tag,
    output logic              alu_free,
    output logic              mul_free,
    output logic              cdb_valid,
    output ooo_pkg::preg_t    cdb_preg,
    output ooo_pkg::rob_tag_t cdb_tag,
    output ooo_pkg::xlen_t    cdb_value
);
    import ooo_pkg::*;

    mul_state_e                    mul_state;
    logic [$clog2(MUL_CYCLES)-1:0] mul_cnt;
    xlen_t                         mul_a, mul_b, mul_acc, mul_next, alu_result;
    preg_t                         mul_preg;
    rob_tag_t                      mul_tag;
    logic                          mul_start, alu_start, mul_last;

    assign mul_start = issue_valid && (issue_op == OP_MUL);
    assign alu_start = issue_valid && (issue_op != OP_MUL);
    assign mul_last  = (mul_state == MUL_BUSY) && (mul_cnt == MUL_CYCLES - 1);
    assign mul_free  = (mul_state == MUL_IDLE);
    assign alu_free  = !mul_last;  // bus slot reserved for the product
    assign mul_next  = mul_acc + (mul_b[0] ? mul_a : '0);

    always_comb begin
        case (issue_op)
            OP_SUB:  alu_result = issue_a - issue_b;
            OP_AND:  alu_result = issue_a & issue_b;
            OP_OR:   alu_result = issue_a | issue_b;
            OP_XOR:  alu_result = issue_a ^ issue_b;
            OP_SLL:  alu_result = issue_a << issue_b[4:0];
            OP_SRL:  alu_result = issue_a >> issue_b[4:0];
            OP_SRA:  alu_result = $signed(issue_a) >>> issue_b[4:0];
            OP_SLT:  alu_result = {31'b0, $signed(issue_a) < $signed(issue_b)};
            OP_SLTU: alu_result = {31'b0, issue_a < issue_b};
            default: alu_result = issue_a + issue_b;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mul_state <= MUL_IDLE;
            mul_cnt   <= '0;
            cdb_valid <= 1'b0;
        end else begin
            cdb_valid <= alu_start || mul_last;
            case (mul_state)
                MUL_IDLE: begin
                    if (mul_start) begin
                        mul_state <= MUL_BUSY;
                        mul_cnt   <= '0;
                    end
                end
                default: begin
                    mul_cnt <= mul_cnt + 1'b1;
                    if (mul_last)
                        mul_state <= MUL_IDLE;
                end
            endcase
        end
    end

    // shift-add datapath and bus register
    always_ff @(posedge clk) begin
        if (mul_start) begin
            mul_a    <= issue_a;
            mul_b    <= issue_b;
            mul_acc  <= '0;
            mul_preg <= issue_preg;
            mul_tag  <= issue_tag;
        end else if (mul_state == MUL_BUSY) begin
            mul_acc <= mul_next;
            mul_a   <= mul_a << 1;
            mul_b   <= mul_b >> 1;
        end
        if (mul_last) begin
            cdb_value <= mul_next;
            cdb_preg  <= mul_preg;
            cdb_tag   <= mul_tag;
        end else if (alu_start) begin
            cdb_value <= alu_result;
            cdb_preg  <= issue_preg;
            cdb_tag   <= issue_tag;
        end
    end

endmodule

//--- source/reorder_buffer.sv
`timescale 1ns/100ps
module reorder_buffer (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              alloc_en,
    input  ooo_pkg::areg_t    alloc_rd,
    input  logic              alloc_we,
    input  ooo_pkg::preg_t    alloc_old_preg,
    output ooo_pkg::rob_tag_t alloc_tag,
    output logic              rob_full,
    input  logic              cdb_valid,
    input  ooo_pkg::rob_tag_t cdb_tag,
    input  ooo_pkg::xlen_t    cdb_value,
    output logic              commit_valid,
    output logic              commit_we,
    output ooo_pkg::areg_t    commit_rd,
    output ooo_pkg::xlen_t    commit_value,
    output logic              release_en,
    output ooo_pkg::preg_t    release_preg
);
    import ooo_pkg::*;

    logic [ROB_DEPTH-1:0] ent_done, ent_we;
    areg_t                ent_rd    [ROB_DEPTH];
    preg_t                ent_old   [ROB_DEPTH];
    xlen_t                ent_value [ROB_DEPTH];

    rob_tag_t                   head, tail;
    logic [$clog2(ROB_DEPTH):0] count;

    assign alloc_tag    = tail;
    assign rob_full     = (count == ROB_DEPTH);
    assign commit_valid = (count != '0) && ent_done[head];
    assign commit_we    = commit_valid && ent_we[head];
    assign commit_rd    = ent_rd[head];
    assign commit_value = ent_value[head];
    assign release_en   = commit_we;  // previous mapping of rd is dead now
    assign release_preg = ent_old[head];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head     <= '0;
            tail     <= '0;
            count    <= '0;
            ent_done <= '0;
            ent_we   <= '0;
            for (int i = 0; i < ROB_DEPTH; i++) begin
                ent_rd[i]    <= '0;
                ent_old[i]   <= '0;
                ent_value[i] <= '0;
            end
        end else begin
            if (alloc_en) begin
                ent_done[tail] <= 1'b0;
                ent_we[tail]   <= alloc_we;
                ent_rd[tail]   <= alloc_rd;
                ent_old[tail]  <= alloc_old_preg;
                tail           <= tail + 1'b1;
            end
            if (cdb_valid) begin
                ent_done[cdb_tag]  <= 1'b1;
                ent_value[cdb_tag] <= cdb_value;
            end
            if (commit_valid)
                head <= head + 1'b1;
            if (alloc_en && !commit_valid)
                count <= count + 1'b1;
            else if (commit_valid && !alloc_en)
                count <= count - 1'b1;
        end
    end

endmodule

//--- source/ooo_core_top.sv
`timescale 1ns/100ps
module ooo_core_top (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           inst_valid,
    input  ooo_pkg::xlen_t inst,
    output logic           full,
    output logic           commit_valid,
    output logic           commit_we,
    output ooo_pkg::areg_t commit_rd,
    output ooo_pkg::xlen_t commit_value
);
    import ooo_pkg::*;

    areg_t    rs1, rs2, rd;
    op_t      op, issue_op;
    xlen_t    imm, src1_value, src2_value, issue_a, issue_b, cdb_value;
    preg_t    src1_preg, src2_preg, dest_preg, old_preg, release_preg, issue_preg, cdb_preg;
    rob_tag_t rob_tag, issue_tag, cdb_tag;
    logic     use_imm, rd_we, accept, free_empty, rob_full, rs_full;
    logic     src1_ready, src2_ready, release_en, issue_valid;
    logic     alu_free, mul_free, cdb_valid;

    assign full   = rob_full || rs_full || free_empty;
    assign accept = inst_valid && !full;

    inst_decoder u_dec (
        .inst(inst), .rs1(rs1), .rs2(rs2), .rd(rd), .op(op),
        .use_imm(use_imm), .imm(imm), .rd_we(rd_we)
    );

    rename_table u_rat (
        .clk(clk), .arst_n(arst_n), .rename_en(accept),
        .rs1(rs1), .rs2(rs2), .rd(rd), .rd_we(rd_we),
        .src1_preg(src1_preg), .src2_preg(src2_preg), .dest_preg(dest_preg),
        .old_preg(old_preg), .free_empty(free_empty),
        .release_en(release_en), .release_preg(release_preg)
    );

    phys_reg_file u_prf (
        .clk(clk), .arst_n(arst_n), .rd_addr1(src1_preg), .rd_addr2(src2_preg),
        .rd_data1(src1_value), .rd_data2(src2_value),
        .rd_valid1(src1_ready), .rd_valid2(src2_ready),
        .alloc_en(accept), .alloc_preg(dest_preg),
        .cdb_valid(cdb_valid), .cdb_preg(cdb_preg), .cdb_value(cdb_value)
    );

    reservation_station u_rs (
        .clk(clk), .arst_n(arst_n), .insert_en(accept), .op(op),
        .use_imm(use_imm), .imm(imm), .src1_preg(src1_preg), .src2_preg(src2_preg),
        .src1_ready(src1_ready), .src2_ready(src2_ready),
        .src1_value(src1_value), .src2_value(src2_value),
        .dest_preg(dest_preg), .tag(rob_tag), .rs_full(rs_full),
        .alu_free(alu_free), .mul_free(mul_free),
        .cdb_valid(cdb_valid), .cdb_preg(cdb_preg), .cdb_value(cdb_value),
        .issue_valid(issue_valid), .issue_op(issue_op), .issue_a(issue_a),
        .issue_b(issue_b), .issue_preg(issue_preg), .issue_tag(issue_tag)
    );

    exec_unit u_exu (
        .clk(clk), .arst_n(arst_n), .issue_valid(issue_valid), .issue_op(issue_op),
        .issue_a(issue_a), .issue_b(issue_b), .issue_preg(issue_preg),
        .issue_tag(issue_tag), .alu_free(alu_free), .mul_free(mul_free),
        .cdb_valid(cdb_valid), .cdb_preg(cdb_preg), .cdb_tag(cdb_tag),
        .cdb_value(cdb_value)
    );

    reorder_buffer u_rob (
        .clk(clk), .arst_n(arst_n), .alloc_en(accept), .alloc_rd(rd),
        .alloc_we(rd_we), .alloc_old_preg(old_preg), .alloc_tag(rob_tag),
        .rob_full(rob_full), .cdb_valid(cdb_valid), .cdb_tag(cdb_tag),
        .cdb_value(cdb_value), .commit_valid(commit_valid), .commit_we(commit_we),
        .commit_rd(commit_rd), .commit_value(commit_value),
        .release_en(release_en), .release_preg(release_preg)
    );

endmodule

//--- verif/ooo_core_assert.sv
`timescale 1ns/100ps
module ooo_core_sva (
    input logic           clk,
    input logic           arst_n,
    input logic           inst_valid,
    input ooo_pkg::xlen_t inst,
    input logic           full,
    input logic           commit_valid,
    input logic           commit_we,
    input ooo_pkg::areg_t commit_rd,
    input ooo_pkg::xlen_t commit_value
);

    int unsigned fail_count = 0;

    no_commit_in_reset: assert property (@(posedge clk) !arst_n |-> !commit_valid)
        else begin
            $error("commit_valid high while in reset");
            fail_count++;
        end

    // x0 never written back
    write_has_rd: assert property (@(posedge clk) disable iff (!arst_n)
        commit_we |-> commit_rd != '0)
        else begin
            $error("commit_we with rd x0");
            fail_count++;
        end

    ports_known: assert property (@(posedge clk) disable iff (!arst_n)
        !$isunknown({inst_valid, inst, full, commit_valid, commit_we, commit_rd, commit_value}))
        else begin
            $error("X on a top-level port");
            fail_count++;
        end

endmodule

bind ooo_core_top ooo_core_sva u_sva (.*);

//--- verif/ooo_core_tb.sv
`timescale 1ns/100ps
module ooo_core_tb;

    localparam logic [6:0] OPC_R     = 7'b0110011;
    localparam logic [6:0] OPC_I     = 7'b0010011;
    localparam logic [6:0] OPC_LUI   = 7'b0110111;
    localparam logic [6:0] F7_MUL    = 7'b0000001;
    localparam int         WAIT_MAX  = 200;
    localparam int         DRAIN_MAX = 4000;

    logic        clk;
    logic        arst_n;
    logic        inst_valid;
    logic [31:0] inst;
    logic        full;
    logic        commit_valid;
    logic        commit_we;
    logic [4:0]  commit_rd;
    logic [31:0] commit_value;

    logic [31:0] arch [32];
    logic [37:0] exp_q [$];  // {we, rd, value}
    int          errors    = 0;
    int          timeouts  = 0;
    int          accepted  = 0;
    int          committed = 0;
    bit          saw_full  = 1'b0;

    ooo_core_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] r_word(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                           logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_R};
    endfunction

    function automatic logic [31:0] i_word(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                           logic [4:0] rd);
        return {imm, rs1, f3, rd, OPC_I};
    endfunction

    function automatic logic [31:0] lui_word(logic [19:0] imm, logic [4:0] rd);
        return {imm, rd, OPC_LUI};
    endfunction

    // architectural RV32 model, one accepted word at a time
    function automatic void model_step(logic [31:0] w);
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        rd = w[11:7];
        a  = arch[w[19:15]];
        b  = (w[6:0] == OPC_R) ? arch[w[24:20]] : {{20{w[31]}}, w[31:20]};
        if (w[6:0] == OPC_LUI) begin
            res = {w[31:12], 12'b0};
        end else if (w[6:0] == OPC_R && w[25]) begin
            res = a * b;  // low half only
        end else begin
            case (w[14:12])
                3'b000:  res = (w[6:0] == OPC_R && w[30]) ? a - b : a + b;
                3'b001:  res = a << b[4:0];
                3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                3'b011:  res = (a < b) ? 32'd1 : 32'd0;
                3'b100:  res = a ^ b;
                3'b101: begin
                    if (w[30])
                        res = $signed(a) >>> b[4:0];
                    else
                        res = a >> b[4:0];
                end
                3'b110:  res = a | b;
                default: res = a & b;
            endcase
        end
        if (rd != 5'd0)
            arch[rd] = res;
        exp_q.push_back({rd != 5'd0, rd, res});
    endfunction

    // called 1 ns after a rising edge, returns 1 ns after the accept edge
    task automatic send(logic [31:0] w);
        int waited;
        if (timeouts != 0)
            return;
        waited     = 0;
        inst_valid = 1'b1;
        inst       = w;
        @(negedge clk);
        while (full && waited < WAIT_MAX) begin
            saw_full = 1'b1;
            waited++;
            @(negedge clk);
        end
        if (full) begin
            $display("timeout at %0t: full stayed high for %0d cycles", $time, WAIT_MAX);
            timeouts++;
        end else begin
            model_step(w);
            accepted++;
        end
        @(posedge clk);
        #1;
        inst_valid = 1'b0;
    endtask

    // chained picks any registers, otherwise x16..x31 written from x0..x15
    task automatic send_random(int n, bit chained);
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        int          kind;
        for (int k = 0; k < n; k++) begin
            f3   = 3'($urandom_range(7, 0));
            rd   = chained ? 5'($urandom_range(31, 1)) : 5'($urandom_range(31, 16));
            rs1  = chained ? 5'($urandom_range(31, 0)) : 5'($urandom_range(15, 0));
            rs2  = chained ? 5'($urandom_range(31, 0)) : 5'($urandom_range(15, 0));
            imm  = 12'($urandom);
            kind = $urandom_range(2, 0);
            if (f3 == 3'b001)
                imm[11:5] = 7'b0;
            else if (f3 == 3'b101)
                imm[11:5] = {1'b0, imm[10], 5'b0};  // srli or srai
            if (kind == 0)
                send(r_word((f3 == 3'b000 || f3 == 3'b101) ? {1'b0, imm[10], 5'b0} : 7'b0,
                            rs2, rs1, f3, rd));
            else if (kind == 1)
                send(i_word(imm, rs1, f3, rd));
            else
                send(lui_word(20'($urandom), rd));
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_MAX) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout: %0d instructions never committed", exp_q.size());
            timeouts++;
        end
    endtask

    initial begin : commit_check
        logic [37:0] want;
        forever begin
            @(negedge clk);
            if (arst_n && commit_valid) begin
                committed++;
                assert (exp_q.size() != 0) else begin
                    $display("commit at %0t with no instruction outstanding", $time);
                    errors++;
                end
                if (exp_q.size() != 0) begin
                    want = exp_q.pop_front();
                    assert (commit_we == want[37] && commit_rd == want[36:32]) else begin
                        $display("ERR %0t: commit we/rd %0b/x%0d, expected %0b/x%0d",
                                 $time, commit_we, commit_rd, want[37], want[36:32]);
                        errors++;
                    end
                    assert (!want[37] || commit_value == want[31:0]) else begin
                        $display("ERR %0t: x%0d = %h, expected %h",
                                 $time, commit_rd, commit_value, want[31:0]);
                        errors++;
                    end
                end
            end
        end
    end

    initial begin
        void'($urandom(83));
        arst_n     = 1'b0;
        inst_valid = 1'b0;
        inst       = '0;
        for (int i = 0; i < 32; i++)
            arch[i] = '0;
        repeat (16) @(posedge clk);
        #1;
        arst_n = 1'b1;
        @(negedge clk);
        assert (!commit_valid && !full) else begin
            $display("ERR %0t: after reset commit_valid=%0b full=%0b, expected both low",
                     $time, commit_valid, full);
            errors++;
        end
        @(posedge clk);
        #1;

        for (int r = 1; r < 16; r++) begin
            send(lui_word(20'($urandom), 5'(r)));
            send(i_word(12'($urandom), 5'(r), 3'b000, 5'(r)));
        end
        send_random(40, 1'b0);
        drain();

        send(i_word(12'd5, 5'd0, 3'b000, 5'd20));
        send(r_word(7'b0, 5'd20, 5'd20, 3'b000, 5'd21));
        send(r_word(7'b0100000, 5'd1, 5'd21, 3'b000, 5'd21));
        send(i_word(12'd3, 5'd21, 3'b001, 5'd21));
        send(r_word(7'b0100000, 5'd20, 5'd21, 3'b101, 5'd21));  // sra by x20
        send(r_word(7'b0, 5'd21, 5'd20, 3'b010, 5'd22));
        send_random(40, 1'b1);
        drain();

        send(r_word(F7_MUL, 5'd2, 5'd1, 3'b000, 5'd16));
        send_random(6, 1'b0);
        send(r_word(F7_MUL, 5'd16, 5'd16, 3'b000, 5'd17));  // waits on a product
        send(r_word(F7_MUL, 5'd3, 5'd0, 3'b000, 5'd18));
        drain();

        saw_full = 1'b0;
        send(r_word(F7_MUL, 5'd4, 5'd5, 3'b000, 5'd20));
        for (int k = 0; k < 10; k++)
            send(r_word(7'b0, 5'(k + 1), 5'd20, 3'b000, 5'(21 + k)));
        drain();
        assert (saw_full) else begin
            $display("full never rose during the dependent burst");
            errors++;
        end

        send(i_word(12'h123, 5'd1, 3'b000, 5'd0));
        send(r_word(7'b0, 5'd2, 5'd3, 3'b111, 5'd0));
        send(lui_word(20'hfffff, 5'd0));
        send(r_word(7'b0, 5'd0, 5'd0, 3'b110, 5'd6));
        send(i_word(12'h7ff, 5'd0, 3'b100, 5'd7));
        send(r_word(F7_MUL, 5'd0, 5'd9, 3'b000, 5'd8));
        drain();

        assert (committed == accepted) else begin
            $display("ERR %0t: committed %0d of %0d accepted instructions",
                     $time, committed, accepted);
            errors++;
        end
        $display("errors: %0d, timeouts: %0d, assertion failures: %0d, committed: %0d of %0d",
                 errors, timeouts, UUT.u_sva.fail_count, committed, accepted);
        if (errors == 0 && timeouts == 0 && UUT.u_sva.fail_count == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

//--- list.f
source/ooo_pkg.sv
source/inst_decoder.sv
source/rename_table.sv
source/phys_reg_file.sv
source/reservation_station.sv
source/exec_unit.sv
source/reorder_buffer.sv
source/ooo_core_top.sv
verif/ooo_core_assert.sv
verif/ooo_core_tb.sv

//--- Bender.yml
package:
  name: ooo_core

sources:
  - source/ooo_pkg.sv
  - source/inst_decoder.sv
  - source/rename_table.sv
  - source/phys_reg_file.sv
  - source/reservation_station.sv
  - source/exec_unit.sv
  - source/reorder_buffer.sv
  - source/ooo_core_top.sv
  - target: test
    files:
      - verif/ooo_core_assert.sv
      - verif/ooo_core_tb.sv
